// File: verilog/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath width in bits
`define WORD_W 16

// number of architectural registers
`define REG_CNT 16

// depth of each memory in 16-bit words
`define MEM_WORDS 1024

// the memory index is taken from the byte address
// with bit 0 dropped

`endif

// File: verilog/isa_pkg.sv
`include "cpu_defines.svh"

package isa_pkg;

	// one data or address word
	typedef logic [`WORD_W-1:0] word_t;

	// register number as found in the rd/rs/rt fields
	typedef logic [$clog2(`REG_CNT)-1:0] reg_idx_t;

	// opcode in instruction bits 15:12
	// RED and PADDSB are kept so the encoding is complete
	typedef enum logic [3:0] {
		OP_ADD    = 4'b0000,
		OP_SUB    = 4'b0001,
		OP_RED    = 4'b0010,
		OP_XOR    = 4'b0011,
		OP_SLL    = 4'b0100,
		OP_SRA    = 4'b0101,
		OP_ROR    = 4'b0110,
		OP_PADDSB = 4'b0111,
		OP_LW     = 4'b1000,
		OP_SW     = 4'b1001,
		OP_LLB    = 4'b1010,
		OP_LHB    = 4'b1011,
		OP_B      = 4'b1100,
		OP_BR     = 4'b1101,
		OP_PCS    = 4'b1110,
		OP_HLT    = 4'b1111
	} opcode_e;

	// branch condition in bits 11:9
	typedef enum logic [2:0] {
		COND_NE     = 3'b000,
		COND_EQ     = 3'b001,
		COND_GT     = 3'b010,
		COND_LT     = 3'b011,
		COND_GE     = 3'b100,
		COND_LE     = 3'b101,
		COND_OV     = 3'b110,
		COND_UNCOND = 3'b111
	} cond_e;

endpackage

// File: verilog/ctrl_pkg.sv
package ctrl_pkg;

	// flag vector, bit 2 is Z, bit 1 is V, bit 0 is N
	typedef logic [2:0] flags_t;

	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 0;

	// what the register file gets written with
	typedef enum logic [2:0] {
		WB_ALU = 3'd0,
		WB_MEM = 3'd1,
		WB_PCS = 3'd2,
		WB_LLB = 3'd3,
		WB_LHB = 3'd4
	} wb_src_e;

	// alu operation, same as the low three opcode bits
	typedef enum logic [2:0] {
		ALU_ADD = 3'b000,
		ALU_SUB = 3'b001,
		ALU_XOR = 3'b011,
		ALU_SLL = 3'b100,
		ALU_SRA = 3'b101,
		ALU_ROR = 3'b110
	} alu_op_e;

endpackage

// File: verilog/memory1c.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module memory1c (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           enable,
	input  logic           wr,
	input  isa_pkg::word_t addr,
	input  isa_pkg::word_t data_in,
	output isa_pkg::word_t data_out
);

	localparam int AW = $clog2(`MEM_WORDS);

	isa_pkg::word_t mem [`MEM_WORDS];
	logic [AW-1:0]  word_addr;

	// byte address in, bit 0 ignored
	assign word_addr = addr[AW:1];

	// write at the edge, held off while in reset
	always_ff @(posedge clk) begin
		if (rst_n && enable && wr) begin
			mem[word_addr] <= data_in;
		end
	end

	// asynchronous read, zero when the block is idle
	assign data_out = enable ? mem[word_addr] : '0;

endmodule

// File: verilog/pc_control.sv
`timescale 1ns/10ps

module pc_control (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             halt,
	input  isa_pkg::opcode_e opcode,
	input  isa_pkg::cond_e   cond,
	input  logic [8:0]       offset,
	input  isa_pkg::word_t   branch_target,
	input  ctrl_pkg::flags_t flags,
	output isa_pkg::word_t   pc,
	output isa_pkg::word_t   pc_plus2
);

	localparam int W = $bits(isa_pkg::word_t);

	logic           taken;
	logic           z, v, n;
	isa_pkg::word_t b_target;
	isa_pkg::word_t pc_next;

	assign z = flags[ctrl_pkg::FLAG_Z];
	assign v = flags[ctrl_pkg::FLAG_V];
	assign n = flags[ctrl_pkg::FLAG_N];

	assign pc_plus2 = pc + isa_pkg::word_t'(2);

	// word offset, so shifted left by one and sign extended
	assign b_target = pc_plus2 + {{(W-10){offset[8]}}, offset, 1'b0};

	// condition check against the current flags
	always_comb begin
		case (cond)
			isa_pkg::COND_NE:     taken = !z;
			isa_pkg::COND_EQ:     taken = z;
			isa_pkg::COND_GT:     taken = !z && !n;
			isa_pkg::COND_LT:     taken = n;
			isa_pkg::COND_GE:     taken = z || !n;
			isa_pkg::COND_LE:     taken = z || n;
			isa_pkg::COND_OV:     taken = v;
			default:              taken = 1'b1;
		endcase
	end

	always_comb begin
		case (opcode)
			isa_pkg::OP_B:  pc_next = taken ? b_target : pc_plus2;
			isa_pkg::OP_BR: pc_next = taken ? branch_target : pc_plus2;
			default:        pc_next = pc_plus2;
		endcase
	end

	// hlt keeps refetching itself, so pc stays put until reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (!halt) begin
			pc <= pc_next;
		end
	end

endmodule

// File: verilog/control_unit.sv
`timescale 1ns/10ps

module control_unit (
	input  isa_pkg::opcode_e  opcode,
	output logic              reg_write,
	output logic              mem_read,
	output logic              mem_write,
	output logic              alu_src,
	output ctrl_pkg::flags_t  flag_wen,
	output ctrl_pkg::wb_src_e wb_src,
	output logic              halt
);

	always_comb begin
		// everything off, RED and PADDSB fall through as no-ops
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		alu_src   = 1'b0;
		flag_wen  = 3'b000;
		wb_src    = ctrl_pkg::WB_ALU;
		halt      = 1'b0;
		case (opcode)
			isa_pkg::OP_ADD, isa_pkg::OP_SUB: begin
				reg_write = 1'b1;
				flag_wen  = 3'b111;
			end
			isa_pkg::OP_XOR: begin
				reg_write = 1'b1;
				flag_wen  = 3'b100;
			end
			// shift amount comes from the immediate field
			isa_pkg::OP_SLL, isa_pkg::OP_SRA, isa_pkg::OP_ROR: begin
				reg_write = 1'b1;
				alu_src   = 1'b1;
				flag_wen  = 3'b100;
			end
			isa_pkg::OP_LW: begin
				reg_write = 1'b1;
				mem_read  = 1'b1;
				wb_src    = ctrl_pkg::WB_MEM;
			end
			// store leaves the register file alone
			isa_pkg::OP_SW:  mem_write = 1'b1;
			isa_pkg::OP_LLB: begin
				reg_write = 1'b1;
				wb_src    = ctrl_pkg::WB_LLB;
			end
			isa_pkg::OP_LHB: begin
				reg_write = 1'b1;
				wb_src    = ctrl_pkg::WB_LHB;
			end
			isa_pkg::OP_PCS: begin
				reg_write = 1'b1;
				wb_src    = ctrl_pkg::WB_PCS;
			end
			isa_pkg::OP_HLT: halt = 1'b1;
			default: ;
		endcase
	end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module register_file (
	input  logic              clk,
	input  logic              rst_n,
	input  isa_pkg::reg_idx_t src1,
	input  isa_pkg::reg_idx_t src2,
	input  isa_pkg::reg_idx_t dst,
	input  logic              write,
	input  isa_pkg::word_t    dst_data,
	output isa_pkg::word_t    src1_data,
	output isa_pkg::word_t    src2_data
);

	isa_pkg::word_t regs [`REG_CNT];

	// reset clears every register and wins over a write
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write && dst != '0) begin
			regs[dst] <= dst_data;
		end
	end

	// r0 is hardwired to zero
	assign src1_data = (src1 == '0) ? '0 : regs[src1];
	assign src2_data = (src2 == '0) ? '0 : regs[src2];

endmodule

// File: verilog/alu.sv
`timescale 1ns/10ps

module alu (
	input  logic              clk,
	input  logic              rst_n,
	input  ctrl_pkg::alu_op_e op,
	input  isa_pkg::word_t    a,
	input  isa_pkg::word_t    b,
	input  ctrl_pkg::flags_t  flag_wen,
	output isa_pkg::word_t    result,
	output ctrl_pkg::flags_t  flags
);

	localparam int W = $bits(isa_pkg::word_t);

	isa_pkg::word_t   sum;
	isa_pkg::word_t   diff;
	logic [2*W-1:0]   rot;
	logic             v_add;
	logic             v_sub;
	ctrl_pkg::flags_t new_flags;

	assign sum  = a + b;
	assign diff = a - b;

	// signed overflow, operand signs against result sign
	assign v_add = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
	assign v_sub = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);

	// rotate right via a doubled word
	assign rot = {a, a} >> b[3:0];

	always_comb begin
		case (op)
			ctrl_pkg::ALU_ADD: result = sum;
			ctrl_pkg::ALU_SUB: result = diff;
			ctrl_pkg::ALU_XOR: result = a ^ b;
			ctrl_pkg::ALU_SLL: result = a << b[3:0];
			ctrl_pkg::ALU_SRA: result = isa_pkg::word_t'($signed(a) >>> b[3:0]);
			ctrl_pkg::ALU_ROR: result = rot[W-1:0];
			default:           result = '0;
		endcase
	end

	always_comb begin
		new_flags[ctrl_pkg::FLAG_Z] = (result == '0);
		new_flags[ctrl_pkg::FLAG_V] = (op == ctrl_pkg::ALU_SUB) ? v_sub : v_add;
		new_flags[ctrl_pkg::FLAG_N] = result[W-1];
	end

	// each flag only moves when its enable is set
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags <= '0;
		end else begin
			for (int i = 0; i < $bits(ctrl_pkg::flags_t); i++) begin
				if (flag_wen[i]) begin
					flags[i] <= new_flags[i];
				end
			end
		end
	end

endmodule

// File: verilog/cpu.sv
`timescale 1ns/10ps

module cpu (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           prog_we,
	input  isa_pkg::word_t prog_addr,
	input  isa_pkg::word_t prog_data,
	output logic           hlt,
	output isa_pkg::word_t pc
);

	localparam int W = $bits(isa_pkg::word_t);

	isa_pkg::word_t    instruction;
	isa_pkg::word_t    imem_addr;
	isa_pkg::word_t    pc_plus2;
	isa_pkg::opcode_e  opcode;
	isa_pkg::reg_idx_t rd_idx;
	isa_pkg::reg_idx_t src1_idx;
	isa_pkg::reg_idx_t src2_idx;
	isa_pkg::word_t    src1_data;
	isa_pkg::word_t    src2_data;
	isa_pkg::word_t    imm;
	isa_pkg::word_t    alu_b;
	isa_pkg::word_t    alu_result;
	isa_pkg::word_t    mem_addr;
	isa_pkg::word_t    mem_data;
	isa_pkg::word_t    wb_data;
	ctrl_pkg::flags_t  flags;
	ctrl_pkg::flags_t  flag_wen;
	ctrl_pkg::wb_src_e wb_src;
	logic              reg_write;
	logic              mem_read;
	logic              mem_write;
	logic              alu_src;

	// fetch
	// load port takes the address while the boot loader writes
	assign imem_addr = prog_we ? prog_addr : pc;

	// imem rst_n tied high, the program is written while the core sits in reset
	memory1c u_imem (
		.clk      (clk),
		.rst_n    (1'b1),
		.enable   (1'b1),
		.wr       (prog_we),
		.addr     (imem_addr),
		.data_in  (prog_data),
		.data_out (instruction)
	);

	pc_control u_pc (
		.clk           (clk),
		.rst_n         (rst_n),
		.halt          (hlt),
		.opcode        (opcode),
		.cond          (isa_pkg::cond_e'(instruction[11:9])),
		.offset        (instruction[8:0]),
		.branch_target (src2_data),
		.flags         (flags),
		.pc            (pc),
		.pc_plus2      (pc_plus2)
	);

	// decode
	assign opcode = isa_pkg::opcode_e'(instruction[15:12]);
	assign rd_idx = instruction[11:8];

	control_unit u_ctrl (
		.opcode    (opcode),
		.reg_write (reg_write),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.alu_src   (alu_src),
		.flag_wen  (flag_wen),
		.wb_src    (wb_src),
		.halt      (hlt)
	);

	// LLB/LHB read rd on port 1 to keep the other byte
	assign src1_idx = (wb_src == ctrl_pkg::WB_LLB || wb_src == ctrl_pkg::WB_LHB) ?
		rd_idx : instruction[7:4];
	// store data sits in the rd field, bits 3:0 hold the offset
	assign src2_idx = mem_write ? rd_idx : instruction[3:0];

	register_file u_rf (
		.clk       (clk),
		.rst_n     (rst_n),
		.src1      (src1_idx),
		.src2      (src2_idx),
		.dst       (rd_idx),
		.write     (reg_write),
		.dst_data  (wb_data),
		.src1_data (src1_data),
		.src2_data (src2_data)
	);

	// execute
	assign imm   = {{(W-4){instruction[3]}}, instruction[3:0]};
	assign alu_b = alu_src ? imm : src2_data;

	alu u_alu (
		.clk      (clk),
		.rst_n    (rst_n),
		.op       (ctrl_pkg::alu_op_e'(instruction[14:12])),
		.a        (src1_data),
		.b        (alu_b),
		.flag_wen (flag_wen),
		.result   (alu_result),
		.flags    (flags)
	);

	// memory
	// base register plus signed byte offset
	assign mem_addr = src1_data + imm;

	memory1c u_dmem (
		.clk      (clk),
		.rst_n    (rst_n),
		.enable   (mem_read | mem_write),
		.wr       (mem_write),
		.addr     (mem_addr),
		.data_in  (src2_data),
		.data_out (mem_data)
	);

	// writeback
	always_comb begin
		case (wb_src)
			ctrl_pkg::WB_MEM: wb_data = mem_data;
			ctrl_pkg::WB_PCS: wb_data = pc_plus2;
			ctrl_pkg::WB_LLB: wb_data = {src1_data[W-1:8], instruction[7:0]};
			ctrl_pkg::WB_LHB: wb_data = {instruction[7:0], src1_data[7:0]};
			default:          wb_data = alu_result;
		endcase
	end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD_NS = 10
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// free running, half period high and half low
	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: tb/cpu_assert.sv
`timescale 1ns/10ps

module cpu_assert (
	input logic           clk,
	input logic           rst_n,
	input logic           hlt,
	input isa_pkg::word_t pc
);

	// instructions are word aligned
	pc_even: assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0)
		else $error("pc is odd");

	// a halted core does not move
	pc_hold: assert property (@(posedge clk) disable iff (!rst_n) hlt |=> pc == $past(pc))
		else $error("pc moved while halted");

	// reset edge brings pc back to the first word
	pc_reset: assert property (@(posedge clk) !rst_n |=> pc == '0)
		else $error("pc not zero after reset");

endmodule

bind cpu cpu_assert u_cpu_assert (
	.clk   (clk),
	.rst_n (rst_n),
	.hlt   (hlt),
	.pc    (pc)
);

// File: tb/cpu_tb.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module cpu_tb;

	localparam int RUNS = 20;
	localparam int CYCLE_LIMIT = 200;
	// every run gets its full cycle budget
	localparam int WATCHDOG_NS = RUNS * CYCLE_LIMIT * 10;

	logic           clk;
	logic           rst_n;
	logic           prog_we;
	isa_pkg::word_t prog_addr;
	isa_pkg::word_t prog_data;
	logic           hlt;
	isa_pkg::word_t pc;

	isa_pkg::word_t prog [$];
	integer         cycles;

	tb_clock #(.PERIOD_NS(10)) u_clk (.clk(clk));

	cpu dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.hlt       (hlt),
		.pc        (pc)
	);

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_word(string what, isa_pkg::word_t got, isa_pkg::word_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag_cycles(string what, integer got, integer exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	// instruction encodings
	function automatic isa_pkg::word_t enc_rrr(isa_pkg::opcode_e op, int rd, int rs, int rt);
		return {op, 4'(rd), 4'(rs), 4'(rt)};
	endfunction

	function automatic isa_pkg::word_t enc_imm8(isa_pkg::opcode_e op, int rd, logic [7:0] imm);
		return {op, 4'(rd), imm};
	endfunction

	function automatic isa_pkg::word_t enc_b(isa_pkg::cond_e c, logic [8:0] off);
		return {isa_pkg::OP_B, c, off};
	endfunction

	function automatic isa_pkg::word_t enc_br(isa_pkg::cond_e c, int rs);
		return {isa_pkg::OP_BR, c, 5'b0, 4'(rs)};
	endfunction

	// condition table against Z, V, N
	function automatic bit cond_holds(isa_pkg::cond_e c, ctrl_pkg::flags_t f);
		bit z;
		bit v;
		bit n;
		z = f[ctrl_pkg::FLAG_Z];
		v = f[ctrl_pkg::FLAG_V];
		n = f[ctrl_pkg::FLAG_N];
		case (c)
			isa_pkg::COND_NE: return !z;
			isa_pkg::COND_EQ: return z;
			isa_pkg::COND_GT: return !z && !n;
			isa_pkg::COND_LT: return n;
			isa_pkg::COND_GE: return z || !n;
			isa_pkg::COND_LE: return z || n;
			isa_pkg::COND_OV: return v;
			default:          return 1'b1;
		endcase
	endfunction

	// add/sub flags from signed integer arithmetic
	function automatic ctrl_pkg::flags_t arith_flags(bit is_sub, isa_pkg::word_t a,
			isa_pkg::word_t b);
		int s;
		isa_pkg::word_t r;
		ctrl_pkg::flags_t f;
		s = is_sub ? ($signed(a) - $signed(b)) : ($signed(a) + $signed(b));
		r = s[15:0];
		f[ctrl_pkg::FLAG_Z] = (r == 0);
		f[ctrl_pkg::FLAG_V] = (s > 32767) || (s < -32768);
		f[ctrl_pkg::FLAG_N] = r[`WORD_W-1];
		return f;
	endfunction

	// reference result of the Z-only operations, one bit step at a time
	function automatic isa_pkg::word_t logic_result(isa_pkg::opcode_e op, isa_pkg::word_t x,
			isa_pkg::word_t y, int sh);
		isa_pkg::word_t r;
		r = x;
		for (int i = 0; i < sh; i++) begin
			case (op)
				isa_pkg::OP_SLL: r = {r[`WORD_W-2:0], 1'b0};
				isa_pkg::OP_SRA: r = {r[`WORD_W-1], r[`WORD_W-1:1]};
				default:         r = {r[0], r[`WORD_W-1:1]};
			endcase
		end
		return (op == isa_pkg::OP_XOR) ? (x ^ y) : r;
	endfunction

	task automatic load_word(int rd, isa_pkg::word_t v);
		prog.push_back(enc_imm8(isa_pkg::OP_LLB, rd, v[7:0]));
		prog.push_back(enc_imm8(isa_pkg::OP_LHB, rd, v[15:8]));
	endtask

	// branch over one HLT into a second one, pc shows the outcome
	task automatic add_branch_tail(isa_pkg::cond_e c, bit taken, output isa_pkg::word_t exp_pc,
			output integer exp_cycles);
		exp_pc = isa_pkg::word_t'(2 * prog.size() + (taken ? 4 : 2));
		exp_cycles = prog.size() + 2;
		prog.push_back(enc_b(c, 9'd1));
		prog.push_back(16'hF000);
		prog.push_back(16'hF000);
	endtask

	// boot load under reset, then release and count cycles to hlt
	task automatic run_program(string name, isa_pkg::word_t exp_pc, integer exp_cycles);
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			rst_n     <= 1'b0;
			prog_we   <= 1'b1;
			prog_addr <= isa_pkg::word_t'(2 * i);
			prog_data <= prog[i];
		end
		@(posedge clk);
		prog_we <= 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!hlt && cycles < CYCLE_LIMIT);
		if (!hlt) begin
			$display("%s: core did not halt within %0d cycles", name, CYCLE_LIMIT);
			abort_run();
		end
		check_word({name, " halt pc"}, pc, exp_pc);
		check_flag_cycles({name, " cycles"}, cycles, exp_cycles);
		prog.delete();
	endtask

	task automatic alu_branch(bit is_sub, isa_pkg::word_t a, isa_pkg::word_t b,
			isa_pkg::cond_e c);
		isa_pkg::word_t exp_pc;
		integer exp_cycles;
		load_word(1, a);
		load_word(2, b);
		prog.push_back(enc_rrr(is_sub ? isa_pkg::OP_SUB : isa_pkg::OP_ADD, 3, 1, 2));
		add_branch_tail(c, cond_holds(c, arith_flags(is_sub, a, b)), exp_pc, exp_cycles);
		run_program("add/sub branch", exp_pc, exp_cycles);
	endtask

	task automatic test_add_sub();
		isa_pkg::word_t a;
		a = $urandom;
		alu_branch(1'b1, a, a, isa_pkg::COND_EQ);
		alu_branch(1'b1, $urandom, $urandom, isa_pkg::COND_GT);
		alu_branch(1'b1, $urandom, $urandom, isa_pkg::COND_LT);
		// two large positives always overflow
		alu_branch(1'b0, 16'h7000 + ($urandom % 256), 16'h7000, isa_pkg::COND_OV);
		alu_branch(1'b0, $urandom, $urandom, isa_pkg::COND_OV);
		alu_branch(1'b1, $urandom, $urandom, isa_pkg::COND_EQ);
	endtask

	task automatic logic_branch(isa_pkg::opcode_e op, isa_pkg::cond_e c);
		isa_pkg::word_t x;
		isa_pkg::word_t y;
		isa_pkg::word_t exp_pc;
		integer exp_cycles;
		int sh;
		ctrl_pkg::flags_t f;
		x  = $urandom;
		y  = ($urandom % 2) ? x : isa_pkg::word_t'($urandom);
		sh = $urandom % 16;
		load_word(1, x);
		load_word(7, y);
		prog.push_back(enc_imm8(isa_pkg::OP_LHB, 5, 8'h80));
		// 0x8000 + 0 leaves N set for the later LT
		prog.push_back(enc_rrr(isa_pkg::OP_ADD, 6, 5, 0));
		prog.push_back(enc_rrr(op, 2, 1, (op == isa_pkg::OP_XOR) ? 7 : sh));
		f = arith_flags(1'b0, 16'h8000, 16'h0000);
		f[ctrl_pkg::FLAG_Z] = (logic_result(op, x, y, sh) == 0);
		add_branch_tail(c, cond_holds(c, f), exp_pc, exp_cycles);
		run_program("logic branch", exp_pc, exp_cycles);
	endtask

	task automatic test_logic_shift();
		logic_branch(isa_pkg::OP_XOR, isa_pkg::COND_EQ);
		logic_branch(isa_pkg::OP_XOR, isa_pkg::COND_LT);
		logic_branch(isa_pkg::OP_SLL, isa_pkg::COND_EQ);
		logic_branch(isa_pkg::OP_SLL, isa_pkg::COND_LT);
		logic_branch(isa_pkg::OP_SRA, isa_pkg::COND_EQ);
		logic_branch(isa_pkg::OP_SRA, isa_pkg::COND_LT);
		logic_branch(isa_pkg::OP_ROR, isa_pkg::COND_EQ);
		logic_branch(isa_pkg::OP_ROR, isa_pkg::COND_LT);
	endtask

	task automatic test_load_store();
		isa_pkg::word_t base;
		isa_pkg::word_t data;
		isa_pkg::word_t exp_pc;
		integer exp_cycles;
		for (int k = 0; k < 2; k++) begin
			base = 16'h0100 + 2 * ($urandom % 64);
			data = $urandom;
			load_word(1, base);
			load_word(4, base - 16'd8);
			load_word(2, data);
			// store at base-4, reload the same word as (base-8)+4
			prog.push_back(enc_rrr(isa_pkg::OP_SW, 2, 1, 4'hC));
			prog.push_back(enc_rrr(isa_pkg::OP_LW, 3, 4, 4'h4));
			prog.push_back(enc_rrr(isa_pkg::OP_SUB, 5, 3, 2));
			add_branch_tail(isa_pkg::COND_EQ, 1'b1, exp_pc, exp_cycles);
			run_program("load/store", exp_pc, exp_cycles);
		end
	endtask

	task automatic test_pcs_loop();
		int n;
		for (int k = 0; k < 2; k++) begin
			n = 1 + $urandom % 8;
			prog.push_back(enc_imm8(isa_pkg::OP_LLB, 1, 8'(n)));
			prog.push_back(enc_imm8(isa_pkg::OP_LLB, 2, 8'd1));
			// r3 gets 6, the address of the SUB
			prog.push_back(enc_imm8(isa_pkg::OP_PCS, 3, 8'h00));
			prog.push_back(enc_rrr(isa_pkg::OP_SUB, 1, 1, 2));
			prog.push_back(enc_br(isa_pkg::COND_NE, 3));
			prog.push_back(16'hF000);
			// setup, n passes of SUB and BR, then HLT
			run_program("pcs loop", 16'd10, 3 + 2 * n + 1);
		end
	endtask

	task automatic test_halt_and_r0();
		isa_pkg::word_t exp_pc;
		integer exp_cycles;
		prog.push_back(16'hF000);
		run_program("halt at zero", 16'd0, 1);
		repeat (3) @(negedge clk);
		check_word("pc held by hlt", pc, 16'd0);
		if (!hlt) begin
			$display("hlt dropped while halted at word 0");
			abort_run();
		end
		// writes to r0 must be lost, so r0 + r0 is zero
		prog.push_back(enc_imm8(isa_pkg::OP_LLB, 0, 8'h01 + 8'($urandom % 255)));
		prog.push_back(enc_rrr(isa_pkg::OP_ADD, 1, 0, 0));
		add_branch_tail(isa_pkg::COND_EQ, 1'b1, exp_pc, exp_cycles);
		run_program("r0 write", exp_pc, exp_cycles);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns", WATCHDOG_NS);
		abort_run();
	end

	initial begin
		rst_n     = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		void'($urandom(20));
		test_add_sub();
		test_logic_shift();
		test_load_store();
		test_pcs_loop();
		test_halt_and_r0();
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: list.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/memory1c.sv
verilog/pc_control.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/alu.sv
verilog/cpu.sv
tb/tb_clock.sv
tb/cpu_assert.sv
tb/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
	-f list.f --top-module cpu_tb -o cpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "compile step failed"
	exit $status
fi

./obj_dir/cpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation reported failure"
	exit $status
fi
exit 0
